// File: tb.f
+incdir+hdl
+incdir+sim
hdl/md_pkg.sv
hdl/md_stage_pipe.sv
hdl/mul_unit.sv
hdl/div_unit.sv
hdl/md_ctrl.sv
hdl/md_unit_top.sv
sim/tb_md_unit.sv

// File: Bender.yml
package:
  name: md_unit

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/md_pkg.sv
      - hdl/md_stage_pipe.sv
      - hdl/mul_unit.sv
      - hdl/div_unit.sv
      - hdl/md_ctrl.sv
      - hdl/md_unit_top.sv
  - target: test
    include_dirs:
      - hdl
      - sim
    files:
      - sim/tb_md_unit.sv

// File: sim/tb_md_model.svh
// Reference model for the eight RV32M multiply/divide operations
// Expected latency and exception, plus the Galois LFSR for stimulus

`ifndef TB_MD_MODEL_SVH
`define TB_MD_MODEL_SVH

// Stages from the accepting edge to the edge that samples done
function automatic int model_latency(input logic [2:0] op);
    return op[2] ? `MD_DIV_LATENCY : `MD_MUL_LATENCY;
endfunction

// Most negative signed word
function automatic logic [`MD_XLEN-1:0] model_min_word();
    return {1'b1, {(`MD_XLEN-1){1'b0}}};
endfunction

// Divide by zero on any divide op, overflow on DIV and REM only
function automatic logic model_exception(input logic [2:0] op,
                                         input logic [`MD_XLEN-1:0] a,
                                         input logic [`MD_XLEN-1:0] b);
    logic overflow;
    overflow = !op[0] && (a == model_min_word()) && (b == '1);
    return op[2] && ((b == '0) || overflow);
endfunction

// Cause 2 for both divider special cases, 0 otherwise
function automatic logic [31:0] model_cause(input logic [2:0] op,
                                            input logic [`MD_XLEN-1:0] a,
                                            input logic [`MD_XLEN-1:0] b);
    return model_exception(op, a, b) ? 32'd2 : 32'd0;
endfunction

// Result word as the ISA defines it, special cases included
function automatic logic [`MD_XLEN-1:0] model_result(input logic [2:0] op,
                                                      input logic [`MD_XLEN-1:0] a,
                                                      input logic [`MD_XLEN-1:0] b);
    logic [2*`MD_XLEN-1:0] a_s;
    logic [2*`MD_XLEN-1:0] a_u;
    logic [2*`MD_XLEN-1:0] b_s;
    logic [2*`MD_XLEN-1:0] b_u;
    logic [2*`MD_XLEN-1:0] prod;
    logic signed [`MD_XLEN-1:0] sa;
    logic signed [`MD_XLEN-1:0] sb;
    logic signed [`MD_XLEN-1:0] sq;
    logic signed [`MD_XLEN-1:0] sr;
    logic ovf;
    a_s  = {{`MD_XLEN{a[`MD_XLEN-1]}}, a};
    a_u  = {{`MD_XLEN{1'b0}}, a};
    b_s  = {{`MD_XLEN{b[`MD_XLEN-1]}}, b};
    b_u  = {{`MD_XLEN{1'b0}}, b};
    sa   = a;
    sb   = b;
    ovf  = (a == model_min_word()) && (b == '1);
    // Signed quotient and remainder, only outside the special cases
    sq   = '0;
    sr   = '0;
    if ((b != '0) && !ovf) begin
        sq = sa / sb;
        sr = sa % sb;
    end
    // Two's complement product modulo 2^64 gives every high-word variant
    case (op)
        3'b000:  prod = a_u * b_u;
        3'b001:  prod = a_s * b_s;
        3'b010:  prod = a_s * b_u;
        default: prod = a_u * b_u;
    endcase
    case (op)
        3'b000:  return prod[`MD_XLEN-1:0];
        3'b100:  return (b == '0) ? '1 : (ovf ? a : sq);
        3'b101:  return (b == '0) ? '1 : a / b;
        3'b110:  return (b == '0) ? a : (ovf ? '0 : sr);
        3'b111:  return (b == '0) ? a : a % b;
        default: return prod[2*`MD_XLEN-1:`MD_XLEN];
    endcase
endfunction

// Galois LFSR step, taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
        next = next ^ 32'h8020_0003;
    end
    return next;
endfunction

`endif

// File: sim/tb_md_unit.sv
// Testbench for the RV32M multiply/divide subsystem
// Clock, reset, stimulus, scoreboard and checking assertions

`timescale 1ns/1ps

`include "md_defs.svh"

module tb_md_unit;

    import md_pkg::*;

    `include "tb_md_model.svh"

    // Longest legal wait for any completion, with margin
    localparam int WAIT_LIMIT = `MD_DIV_LATENCY + `MD_MUL_LATENCY + 8;

    logic   clk_i;
    logic   rst_ni;
    logic   start_i;
    md_op_t op_i;
    word_t  operand_a_i;
    word_t  operand_b_i;
    word_t  result_o;
    logic   done_o;
    logic   busy_o;
    logic   exception_valid_o;
    cause_t exception_cause_o;

    // Scoreboard for the one pending operation
    int          edge_cnt;
    int          pend_due;
    logic        pend_valid;
    word_t       pend_result;
    logic        pend_exc;
    cause_t      pend_cause;
    logic        started;
    logic        exp_done;
    logic        exp_busy;
    logic        exp_accept;
    int          accepted_cnt;
    int          completed_cnt;
    int          mismatch_errors;
    int          other_errors;
    logic [31:0] lfsr_state;

    md_unit_top md_unit_top_i (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .start_i           (start_i),
        .op_i              (op_i),
        .operand_a_i       (operand_a_i),
        .operand_b_i       (operand_b_i),
        .result_o          (result_o),
        .done_o            (done_o),
        .busy_o            (busy_o),
        .exception_valid_o (exception_valid_o),
        .exception_cause_o (exception_cause_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ==================================================================
    // Expected behavior from the latency rule
    // ==================================================================

    // Busy drops on the edge that samples done
    assign exp_done   = pend_valid && (edge_cnt == pend_due);
    assign exp_busy   = pend_valid && (edge_cnt != pend_due);
    assign exp_accept = start_i && !exp_busy;

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            edge_cnt      <= 0;
            pend_due      <= 0;
            pend_valid    <= 1'b0;
            pend_result   <= '0;
            pend_exc      <= 1'b0;
            pend_cause    <= '0;
            started       <= 1'b0;
            accepted_cnt  <= 0;
            completed_cnt <= 0;
        end else begin
            edge_cnt <= edge_cnt + 1;
            // Completions as the DUT reports them
            if (done_o) begin
                completed_cnt <= completed_cnt + 1;
            end
            // A start in the done cycle replaces the finished entry
            if (exp_accept) begin
                pend_valid   <= 1'b1;
                pend_due     <= edge_cnt + model_latency(op_i);
                pend_result  <= model_result(op_i, operand_a_i, operand_b_i);
                pend_exc     <= model_exception(op_i, operand_a_i, operand_b_i);
                pend_cause   <= model_cause(op_i, operand_a_i, operand_b_i);
                started      <= 1'b1;
                accepted_cnt <= accepted_cnt + 1;
            end else if (exp_done) begin
                pend_valid <= 1'b0;
            end
        end
    end

    // ==================================================================
    // Checking assertions
    // ==================================================================

    a_done: assert property (@(posedge clk_i) disable iff (!rst_ni) done_o == exp_done)
        else begin
            mismatch_errors++;
            $display("Mismatch at %0t: done_o = %b, expected %b",
                     $time, $sampled(done_o), $sampled(exp_done));
        end

    a_busy: assert property (@(posedge clk_i) disable iff (!rst_ni) busy_o == exp_busy)
        else begin
            mismatch_errors++;
            $display("Mismatch at %0t: busy_o = %b, expected %b",
                     $time, $sampled(busy_o), $sampled(exp_busy));
        end

    a_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
        exp_done |-> result_o == pend_result)
        else begin
            mismatch_errors++;
            $display("Mismatch at %0t: result_o = %h, expected %h",
                     $time, $sampled(result_o), $sampled(pend_result));
        end

    a_exc_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        exp_done |-> exception_valid_o == pend_exc)
        else begin
            mismatch_errors++;
            $display("Mismatch at %0t: exception_valid_o = %b, expected %b",
                     $time, $sampled(exception_valid_o), $sampled(pend_exc));
        end

    a_exc_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
        exp_done |-> exception_cause_o == pend_cause)
        else begin
            mismatch_errors++;
            $display("Mismatch at %0t: exception_cause_o = %0d, expected %0d",
                     $time, $sampled(exception_cause_o), $sampled(pend_cause));
        end

    // Quiet until the first start
    a_idle_exc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !started |-> !exception_valid_o)
        else begin
            mismatch_errors++;
            $display("Mismatch at %0t: exception_valid_o = 1 before any start, expected 0",
                     $time);
        end

    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_ni |-> (!done_o && !busy_o && !exception_valid_o))
        else begin
            mismatch_errors++;
            $display("Mismatch at %0t: done_o/busy_o/exception_valid_o = %b%b%b, expected 000",
                     $time, $sampled(done_o), $sampled(busy_o), $sampled(exception_valid_o));
        end

    // ==================================================================
    // Stimulus helpers
    // ==================================================================

    // One LFSR step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[`MD_XLEN-2:0], lfsr_state[0]};
        end
        return w;
    endfunction

    // Sign edges, zero, one and small mixed-sign values
    function automatic word_t corner_word(input int idx);
        case (idx)
            0:       return '0;
            1:       return word_t'(1);
            2:       return '1;
            3:       return {1'b1, {(`MD_XLEN-1){1'b0}}};
            4:       return {1'b0, {(`MD_XLEN-1){1'b1}}};
            default: return word_t'(-7);
        endcase
    endfunction

    task automatic print_counts();
        $display("Errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
    endtask

    task automatic report_timeout(input string what);
        other_errors++;
        $display("Timeout: %s", what);
        print_counts();
        $display("Test FAILED");
        $finish;
    endtask

    // Start pulse of one cycle, driven on the falling edge
    task automatic issue_op(input md_op_t op, input word_t a, input word_t b);
        @(negedge clk_i);
        start_i     = 1'b1;
        op_i        = op;
        operand_a_i = a;
        operand_b_i = b;
        @(negedge clk_i);
        start_i = 1'b0;
    endtask

    // Returns on a falling edge with done_o high
    task automatic wait_done();
        int n;
        n = 0;
        while (!done_o && n < WAIT_LIMIT) begin
            @(negedge clk_i);
            n++;
        end
        if (!done_o) begin
            report_timeout("done_o did not arrive");
        end
    endtask

    task automatic run_op(input md_op_t op, input word_t a, input word_t b);
        issue_op(op, a, b);
        wait_done();
    endtask

    // Keep start high on the other path while busy
    task automatic ignored_start_test(input md_op_t op, input word_t a, input word_t b);
        int n;
        issue_op(op, a, b);
        n = 0;
        while (busy_o && n < WAIT_LIMIT) begin
            start_i     = 1'b1;
            op_i        = md_op_t'(op ^ 3'b100);
            operand_a_i = rand_bits(`MD_XLEN);
            operand_b_i = rand_bits(`MD_XLEN);
            @(negedge clk_i);
            n++;
        end
        start_i = 1'b0;
        if (busy_o) begin
            report_timeout("busy_o did not fall");
        end
        wait_done();
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================

    initial begin : main_flow
        md_op_t op_v;
        word_t  a_v;
        word_t  b_v;
        word_t  pick;
        rst_ni          = 1'b0;
        start_i         = 1'b0;
        op_i            = OP_MUL;
        operand_a_i     = '0;
        operand_b_i     = '0;
        mismatch_errors = 0;
        other_errors    = 0;
        lfsr_state      = 32'd37;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        // Idle cycles after reset
        repeat (3) @(negedge clk_i);

        // Every op on every corner pair, zero divisor and overflow included
        for (int op = 0; op < 8; op++) begin
            for (int i = 0; i < 6; i++) begin
                for (int j = 0; j < 6; j++) begin
                    run_op(md_op_t'(op), corner_word(i), corner_word(j));
                end
            end
        end

        // Random ops, about one in eight with a zero divisor
        for (int n = 0; n < 120; n++) begin
            op_v = md_op_t'(rand_bits(3));
            a_v  = rand_bits(`MD_XLEN);
            b_v  = rand_bits(`MD_XLEN);
            if (rand_bits(3) == '0) begin
                b_v = '0;
            end
            run_op(op_v, a_v, b_v);
        end

        // Starts while busy must vanish
        ignored_start_test(OP_DIV, word_t'(1000), word_t'(7));
        ignored_start_test(OP_MULH, corner_word(3), word_t'(3));

        // Back-to-back starts in the done cycle, alternating paths
        a_v = rand_bits(`MD_XLEN);
        b_v = rand_bits(`MD_XLEN);
        run_op(OP_MUL, a_v, b_v);
        for (int n = 0; n < 6; n++) begin
            pick        = rand_bits(2);
            op_v        = md_op_t'({~op_i[2], pick[1:0]});
            start_i     = 1'b1;
            op_i        = op_v;
            operand_a_i = rand_bits(`MD_XLEN);
            operand_b_i = rand_bits(`MD_XLEN);
            @(negedge clk_i);
            start_i = 1'b0;
            wait_done();
        end

        repeat (4) @(negedge clk_i);
        if (accepted_cnt != completed_cnt) begin
            other_errors++;
            $display("Completion count wrong: %0d starts accepted, %0d completions",
                     accepted_cnt, completed_cnt);
        end
        print_counts();
        if (mismatch_errors + other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/md_unit_top.sv
// Top level of the RV32M multiply/divide subsystem
// Connects control with the multiplier and divider paths

`timescale 1ns/1ps

module md_unit_top (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           start_i,
    input  md_pkg::md_op_t op_i,
    input  md_pkg::word_t  operand_a_i,
    input  md_pkg::word_t  operand_b_i,
    output md_pkg::word_t  result_o,
    output logic           done_o,
    output logic           busy_o,
    output logic           exception_valid_o,
    output md_pkg::cause_t exception_cause_o
);

    import md_pkg::*;

    // Control to paths
    logic    mul_start;
    logic    div_start;
    sub_op_t sub_op;

    // Paths back to control
    logic    mul_done;
    word_t   mul_result;
    logic    div_done;
    word_t   div_result;
    logic    div_exc_valid;
    cause_t  div_exc_cause;

    md_ctrl md_ctrl_i (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .start_i           (start_i),
        .op_i              (op_i),
        .mul_done_i        (mul_done),
        .mul_result_i      (mul_result),
        .div_done_i        (div_done),
        .div_result_i      (div_result),
        .div_exc_valid_i   (div_exc_valid),
        .div_exc_cause_i   (div_exc_cause),
        .mul_start_o       (mul_start),
        .div_start_o       (div_start),
        .sub_op_o          (sub_op),
        .result_o          (result_o),
        .done_o            (done_o),
        .busy_o            (busy_o),
        .exception_valid_o (exception_valid_o),
        .exception_cause_o (exception_cause_o)
    );

    // Operands fan out to both paths directly
    mul_unit mul_unit_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (mul_start),
        .sub_op_i    (sub_op),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .done_o      (mul_done),
        .result_o    (mul_result)
    );

    div_unit div_unit_i (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .start_i           (div_start),
        .sub_op_i          (sub_op),
        .operand_a_i       (operand_a_i),
        .operand_b_i       (operand_b_i),
        .done_o            (div_done),
        .result_o          (div_result),
        .exception_valid_o (div_exc_valid),
        .exception_cause_o (div_exc_cause)
    );

endmodule

// File: hdl/md_ctrl.sv
// Control for the multiply/divide subsystem
// Start gating and routing, busy tracking, completion mux

`timescale 1ns/1ps

module md_ctrl (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            start_i,
    input  md_pkg::md_op_t  op_i,
    input  logic            mul_done_i,
    input  md_pkg::word_t   mul_result_i,
    input  logic            div_done_i,
    input  md_pkg::word_t   div_result_i,
    input  logic            div_exc_valid_i,
    input  md_pkg::cause_t  div_exc_cause_i,
    output logic            mul_start_o,
    output logic            div_start_o,
    output md_pkg::sub_op_t sub_op_o,
    output md_pkg::word_t   result_o,
    output logic            done_o,
    output logic            busy_o,
    output logic            exception_valid_o,
    output md_pkg::cause_t  exception_cause_o
);

    import md_pkg::*;

    // ==================================================================
    // State and start routing
    // ==================================================================

    // One operation in flight at most
    logic busy_q;
    // Set while the divider owns the pending operation
    logic sel_div_q;
    logic accept;
    logic path_done;

    // Busy drops in the done cycle, so a back-to-back start is taken
    assign busy_o = busy_q & ~path_done;
    assign accept = start_i & ~busy_o;

    // funct3 bit 2 steers to the divider
    assign mul_start_o = accept & ~op_i[2];
    assign div_start_o = accept & op_i[2];
    assign sub_op_o    = op_i[1:0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q    <= 1'b0;
            sel_div_q <= 1'b0;
        end else begin
            if (accept) begin
                // New start wins over a completion in the same cycle
                busy_q    <= 1'b1;
                sel_div_q <= op_i[2];
            end else if (path_done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // ==================================================================
    // Completion mux
    // ==================================================================

    // Only the recorded path may complete
    assign path_done = sel_div_q ? div_done_i : mul_done_i;
    assign done_o    = path_done;
    assign result_o  = sel_div_q ? div_result_i : mul_result_i;

    // Multiply never raises an exception
    assign exception_valid_o = sel_div_q & div_exc_valid_i;
    assign exception_cause_o = sel_div_q ? div_exc_cause_i : CAUSE_NONE;

    // Path done must belong to the pending operation
    a_mul_done_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mul_done_i |-> (busy_q && !sel_div_q))
        else $error("md_ctrl: multiplier done without a pending multiply");

    a_div_done_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
        div_done_i |-> (busy_q && sel_div_q))
        else $error("md_ctrl: divider done without a pending divide");

    // Busy or an accepted start in the cycle before
    // The start case covers a one-stage path
    a_done_after_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        done_o |-> $past(busy_o || accept))
        else $error("md_ctrl: done_o while idle in the previous cycle");

endmodule

// File: hdl/div_unit.sv
// Divider path for DIV, DIVU, REM and REMU
// RISC-V special cases, exception flag and cause, staged result

`timescale 1ns/1ps

`include "md_defs.svh"

module div_unit (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            start_i,
    input  md_pkg::sub_op_t sub_op_i,
    input  md_pkg::word_t   operand_a_i,
    input  md_pkg::word_t   operand_b_i,
    output logic            done_o,
    output md_pkg::word_t   result_o,
    output logic            exception_valid_o,
    output md_pkg::cause_t  exception_cause_o
);

    import md_pkg::*;

    // Staged payload is {exception flag, cause, result}
    typedef logic [$bits(cause_t)+`MD_XLEN:0] div_payload_t;

    // ==================================================================
    // Operation decode and special cases
    // ==================================================================

    logic         is_signed;
    logic         is_rem;
    logic         div_by_zero;
    logic         signed_overflow;
    word_t        quotient;
    word_t        remainder;
    word_t        div_word;
    logic         exc_valid;
    cause_t       exc_cause;
    div_payload_t pipe_in;
    div_payload_t pipe_out;

    // DIV and REM have funct3 bit 0 clear
    assign is_signed = ~sub_op_i[0];
    // REM and REMU have funct3 bit 1 set
    assign is_rem    = sub_op_i[1];

    assign div_by_zero = (operand_b_i == '0);

    // Most negative dividend over -1, signed ops only
    assign signed_overflow = is_signed &&
                             (operand_a_i == {1'b1, {(`MD_XLEN-1){1'b0}}}) &&
                             (operand_b_i == '1);

    // ==================================================================
    // Quotient and remainder
    // ==================================================================

    // Operators only evaluated on the normal branch
    always_comb begin
        if (div_by_zero) begin
            quotient  = '1;
            remainder = operand_a_i;
        end else if (signed_overflow) begin
            quotient  = operand_a_i;
            remainder = '0;
        end else if (is_signed) begin
            quotient  = $signed(operand_a_i) / $signed(operand_b_i);
            remainder = $signed(operand_a_i) % $signed(operand_b_i);
        end else begin
            quotient  = operand_a_i / operand_b_i;
            remainder = operand_a_i % operand_b_i;
        end
    end

    assign div_word = is_rem ? remainder : quotient;

    // Both special cases flag the same cause
    assign exc_valid = div_by_zero | signed_overflow;
    assign exc_cause = exc_valid ? CAUSE_ILLEGAL_INSTRUCTION : CAUSE_NONE;

    assign pipe_in = {exc_valid, exc_cause, div_word};

    md_stage_pipe #(
        .T_PAYLOAD (div_payload_t),
        .DEPTH     (`MD_DIV_LATENCY)
    ) div_pipe_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .valid_i   (start_i),
        .payload_i (pipe_in),
        .valid_o   (done_o),
        .payload_o (pipe_out)
    );

    assign {exception_valid_o, exception_cause_o, result_o} = pipe_out;

    // Special cases must surface as exceptions at the staged output
    a_div_zero_exc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (start_i && div_by_zero) |-> ##`MD_DIV_LATENCY
            (done_o && exception_valid_o &&
             exception_cause_o == CAUSE_ILLEGAL_INSTRUCTION))
        else $error("div_unit: divide by zero lost its exception");

    a_overflow_exc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (start_i && signed_overflow) |-> ##`MD_DIV_LATENCY
            (done_o && exception_valid_o &&
             exception_cause_o == CAUSE_ILLEGAL_INSTRUCTION))
        else $error("div_unit: signed overflow lost its exception");

endmodule

// File: hdl/mul_unit.sv
// Multiplier path for MUL, MULH, MULHSU and MULHU
// Product formed at the start cycle, then staged to done

`timescale 1ns/1ps

`include "md_defs.svh"

module mul_unit (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            start_i,
    input  md_pkg::sub_op_t sub_op_i,
    input  md_pkg::word_t   operand_a_i,
    input  md_pkg::word_t   operand_b_i,
    output logic            done_o,
    output md_pkg::word_t   result_o
);

    import md_pkg::*;

    // ==================================================================
    // Operand extension
    // ==================================================================

    logic a_is_signed;
    logic b_is_signed;
    logic hi_word;

    // 33-bit operands cover every signed/unsigned mix
    logic signed [`MD_XLEN:0]     a_ext;
    logic signed [`MD_XLEN:0]     b_ext;
    logic signed [2*`MD_XLEN+1:0] product;
    word_t                        mul_word;

    // MULHU is the only op with an unsigned multiplicand
    assign a_is_signed = ({1'b0, sub_op_i} != OP_MULHU);

    // Multiplier is signed for MULH
    // MUL keeps the low word, so its signedness does not matter
    assign b_is_signed = ({1'b0, sub_op_i} == OP_MULH) ||
                         ({1'b0, sub_op_i} == OP_MUL);

    // Everything except MUL returns the upper half
    assign hi_word = ({1'b0, sub_op_i} != OP_MUL);

    assign a_ext = {a_is_signed & operand_a_i[`MD_XLEN-1], operand_a_i};
    assign b_ext = {b_is_signed & operand_b_i[`MD_XLEN-1], operand_b_i};

    // ==================================================================
    // Product and word select
    // ==================================================================

    // Both sides signed, so the 66-bit product is exact
    assign product = a_ext * b_ext;

    always_comb begin
        if (hi_word) begin
            mul_word = product[2*`MD_XLEN-1:`MD_XLEN];
        end else begin
            mul_word = product[`MD_XLEN-1:0];
        end
    end

    // Result rides the pipeline for the fixed latency
    md_stage_pipe #(
        .T_PAYLOAD (word_t),
        .DEPTH     (`MD_MUL_LATENCY)
    ) mul_pipe_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .valid_i   (start_i),
        .payload_i (mul_word),
        .valid_o   (done_o),
        .payload_o (result_o)
    );

    // A done always traces back to a start one latency earlier
    a_done_has_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
        done_o |-> $past(start_i, `MD_MUL_LATENCY))
        else $error("mul_unit: done_o without matching start");

endmodule

// File: hdl/md_stage_pipe.sv
// Fixed-depth valid/payload shift pipeline
// Payload type is a parameter so both datapaths share it

`timescale 1ns/1ps

module md_stage_pipe #(
    parameter type    T_PAYLOAD = logic,
    parameter integer DEPTH     = 1
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     valid_i,
    input  T_PAYLOAD payload_i,
    output logic     valid_o,
    output T_PAYLOAD payload_o
);

    // Chain index 0 is the input, index DEPTH is the last register
    logic [DEPTH:0] valid_chain;
    T_PAYLOAD       payload_chain [DEPTH+1];

    assign valid_chain[0]   = valid_i;
    assign payload_chain[0] = payload_i;

    // One register pair per stage
    for (genvar k = 0; k < DEPTH; k++) begin : g_stage
        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                valid_chain[k+1]   <= 1'b0;
                payload_chain[k+1] <= '0;
            end else begin
                valid_chain[k+1] <= valid_chain[k];
                // Payload moves only along with its valid bit
                if (valid_chain[k]) begin
                    payload_chain[k+1] <= payload_chain[k];
                end
            end
        end
    end

    assign valid_o   = valid_chain[DEPTH];
    assign payload_o = payload_chain[DEPTH];

    // Every accepted item leaves exactly DEPTH cycles later
    a_valid_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_i |-> ##DEPTH valid_o)
        else $error("md_stage_pipe: valid_o missing %0d cycles after valid_i", DEPTH);

endmodule

// File: hdl/md_pkg.sv
// Types and constants for the RV32M multiply/divide subsystem
// Word type, funct3 operation codes, exception causes

`include "md_defs.svh"

package md_pkg;

    // One operand or result word
    typedef logic [`MD_XLEN-1:0] word_t;

    // ==================================================================
    // Operation codes, straight from funct3
    // ==================================================================

    // Bit 2 picks the divider path
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } md_op_t;

    // Low two funct3 bits, handed to the selected path
    typedef logic [1:0] sub_op_t;

    // Exception cause word
    typedef logic [31:0] cause_t;

    localparam cause_t CAUSE_NONE                = 32'd0;
    // Divide by zero and signed overflow both report this one
    localparam cause_t CAUSE_ILLEGAL_INSTRUCTION = 32'd2;

endpackage

// File: hdl/md_defs.svh
// Width and latency macros for the RV32M multiply/divide subsystem
// Shared by the package, the RTL and the testbench

`ifndef MD_DEFS_SVH
`define MD_DEFS_SVH

// ======================================================================
// Datapath width
// ======================================================================

// Operand and result width in bits
`define MD_XLEN 32

// ======================================================================
// Path latencies
// ======================================================================

// Multiplier stages from start pulse to done, at least 1
`define MD_MUL_LATENCY 2

// Divider stages from start pulse to done, at least 1
`define MD_DIV_LATENCY 4

`endif
